// File: verilog.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_ctrl.sv
verilog/adder.sv
verilog/barrel_shifter.sv
verilog/alu.sv
verilog/ex_unit.sv
bench/tb_ex_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ex_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--timescale 1ns/10ps \
	-f verilog.f \
	--top-module tb_ex_unit \
	--Mdir obj_dir \
	-o tb_ex_unit

./obj_dir/tb_ex_unit

// File: bench/tb_ex_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_consts.svh"

module tb_ex_unit;

	import alu_pkg::*;

	localparam int N_TESTS    = 2000;
	localparam int RST_CYCLES = 5;
	localparam int TIMEOUT_NS = (RST_CYCLES + N_TESTS + 20) * 20;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	alu_class_t  alu_class;
	funct3_t     funct3;
	funct7_t     funct7;
	xlen_t       src_a;
	xlen_t       src_b;
	logic        out_valid;
	xlen_t       result;
	logic        zero;
	logic        carry;
	logic        overflow;
	logic        less;

	integer      seed;
	xlen_t       exp_result[$];   // expected results, oldest first
	logic [3:0]  exp_flags[$];    // {zero, carry, overflow, less}
	logic        out_seen;

	ex_unit DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.alu_class (alu_class),
		.funct3    (funct3),
		.funct7    (funct7),
		.src_a     (src_a),
		.src_b     (src_b),
		.out_valid (out_valid),
		.result    (result),
		.zero      (zero),
		.carry     (carry),
		.overflow  (overflow),
		.less      (less)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before all samples came back");
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
		if (actual !== expected) begin
			$display("error: %0t ns: %s expected %h got %h", $time, name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error: %0t ns: %s expected %b got %b", $time, name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// decode table, class first, then funct3 with funct7 bit 5
	function automatic alu_opcode_t decode_op(input alu_class_t cls, input funct3_t f3,
	                                          input funct7_t f7);
		if (cls == `CLASS_MEM) return `OP_ADD;
		if (cls == `CLASS_BRANCH) return `OP_SUB;
		case (f3)
			3'b000:  return (cls == `CLASS_REG && f7[5]) ? `OP_SUB : `OP_ADD;
			3'b001:  return `OP_SLL;
			3'b010:  return `OP_SLT;
			3'b011:  return `OP_SLTU;
			3'b100:  return `OP_XOR;
			3'b101:  return f7[5] ? `OP_SRA : `OP_SRL;
			3'b110:  return `OP_OR;
			default: return `OP_AND;
		endcase
	endfunction

	task automatic model_alu(input alu_opcode_t op, input xlen_t a, input xlen_t b,
	                         output xlen_t res, output logic [3:0] flags);
		logic [`XLEN:0]        wide;
		logic signed [`XLEN:0] wide_s;
		xlen_t                 s;
		shamt_t                sh;
		logic                  c;
		logic                  ov;
		logic                  lt;
		if (op == `OP_ADD) begin
			wide   = {1'b0, a} + {1'b0, b};
			wide_s = $signed({a[`XLEN-1], a}) + $signed({b[`XLEN-1], b});
			s      = wide[`XLEN-1:0];
			c      = wide[`XLEN];
			ov     = (wide_s[`XLEN] != wide_s[`XLEN-1]); // exact sum out of signed range
			lt     = wide_s[`XLEN];                       // sign of the exact sum
		end else begin
			s  = a - b;
			c  = (a >= b); // no borrow
			ov = (a[`XLEN-1] != b[`XLEN-1]) && (s[`XLEN-1] != a[`XLEN-1]);
			lt = (op == `OP_SLTU) ? (a < b) : ($signed(a) < $signed(b));
		end
		sh = b[`SHAMT_W-1:0];
		case (op)
			`OP_AND:           res = a & b;
			`OP_OR:            res = a | b;
			`OP_XOR:           res = a ^ b;
			`OP_SLT, `OP_SLTU: res = {{(`XLEN-1){1'b0}}, lt};
			`OP_SLL:           res = a << sh;
			`OP_SRL:           res = a >> sh;
			`OP_SRA:           res = $signed(a) >>> sh;
			default:           res = s;
		endcase
		flags = {(res == '0), c, ov, lt};
	endtask

	// corner values or a full random word
	function automatic xlen_t pick_operand();
		logic [2:0] sel;
		sel = 3'($random(seed));
		case (sel)
			3'd0:    return '0;
			3'd1:    return '1;
			3'd2:    return {1'b1, {(`XLEN-1){1'b0}}};
			3'd3:    return {1'b0, {(`XLEN-1){1'b1}}};
			default: return {32'($random(seed)), 32'($random(seed))};
		endcase
	endfunction

	initial begin
		xlen_t       a;
		xlen_t       b;
		xlen_t       res;
		logic [3:0]  flags;
		alu_class_t  cls;
		funct3_t     f3;
		funct7_t     f7;
		logic [9:0]  roll;
		logic        valid;
		seed      = 32'h3522fd31;
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		alu_class = '0;
		funct3    = '0;
		funct7    = '0;
		src_a     = '0;
		src_b     = '0;
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < N_TESTS; i++) begin
			@(posedge clk);
			roll  = 10'($random(seed));
			valid = (roll < 10'd717); // about 70 %
			cls   = 2'($random(seed));
			f3    = 3'($random(seed));
			f7    = 7'($random(seed));
			a     = pick_operand();
			b     = pick_operand();
			in_valid  <= valid;
			alu_class <= cls;
			funct3    <= f3;
			funct7    <= f7;
			src_a     <= a;
			src_b     <= b;
			if (valid) begin
				model_alu(decode_op(cls, f3, f7), a, b, res, flags);
				exp_result.push_back(res);
				exp_flags.push_back(flags);
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		repeat (2) @(negedge clk);
		if (exp_result.size() != 0) begin
			$display("%0d samples never came out of the unit", exp_result.size());
			$display("TB FAILED");
			$fatal(1, "pending samples at end of run");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

	// outputs are stable at the falling edge
	initial begin
		xlen_t      res;
		logic [3:0] flags;
		out_seen = 1'b0;
		forever begin
			@(negedge clk);
			if (out_valid) begin
				if (exp_result.size() == 0) begin
					$display("out_valid at %0t ns with no sample pending", $time);
					$display("TB FAILED");
					$fatal(1, "unexpected output");
				end
				res   = exp_result.pop_front();
				flags = exp_flags.pop_front();
				check_word("result", res, result);
				check_flag("zero", flags[3], zero);
				check_flag("carry", flags[2], carry);
				check_flag("overflow", flags[1], overflow);
				check_flag("less", flags[0], less);
				out_seen = 1'b1;
			end else if (!out_seen) begin // reset values until the first output
				check_word("result", '0, result);
				check_flag("zero", 1'b0, zero);
				check_flag("carry", 1'b0, carry);
				check_flag("overflow", 1'b0, overflow);
				check_flag("less", 1'b0, less);
			end
			// only the sample driven at the last edge may still wait
			if (exp_result.size() != (in_valid ? 1 : 0)) begin
				$display("output latency is not one cycle at %0t ns", $time);
				$display("TB FAILED");
				$fatal(1, "latency");
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/ex_unit.sv
`timescale 1ns/10ps
`default_nettype none

module ex_unit (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire                      in_valid,
	input  wire alu_pkg::alu_class_t alu_class,
	input  wire alu_pkg::funct3_t    funct3,
	input  wire alu_pkg::funct7_t    funct7,
	input  wire alu_pkg::xlen_t      src_a,
	input  wire alu_pkg::xlen_t      src_b,
	output logic                     out_valid,
	output alu_pkg::xlen_t           result,
	output logic                     zero,
	output logic                     carry,
	output logic                     overflow,
	output logic                     less
);

	import alu_pkg::*;

	alu_opcode_t opcode; // decoded in the same cycle

	alu_ctrl u_ctrl (
		.alu_class (alu_class),
		.funct3    (funct3),
		.funct7    (funct7),
		.opcode    (opcode)
	);

	alu u_alu (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.opcode    (opcode),
		.a         (src_a),
		.b         (src_b),
		.out_valid (out_valid),
		.result    (result),
		.zero      (zero),
		.carry     (carry),
		.overflow  (overflow),
		.less      (less)
	);

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_consts.svh"

module alu (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       in_valid,
	input  wire alu_pkg::alu_opcode_t opcode,
	input  wire alu_pkg::xlen_t       a,
	input  wire alu_pkg::xlen_t       b,
	output logic                      out_valid,
	output alu_pkg::xlen_t            result,
	output logic                      zero,
	output logic                      carry,
	output logic                      overflow,
	output logic                      less
);

	import alu_pkg::*;

	xlen_t  sum;
	xlen_t  shifted;
	xlen_t  result_c;
	shamt_t shamt;
	logic   sub;
	logic   shift_left;
	logic   shift_arith;
	logic   carry_c;
	logic   overflow_c;
	logic   less_signed;
	logic   less_c;
	logic   zero_c;

	// adder subtracts for everything but add, so flags are always a compare
	assign sub         = (opcode != `OP_ADD);
	assign shift_left  = (opcode == `OP_SLL);
	assign shift_arith = (opcode == `OP_SRA);
	assign shamt       = b[`SHAMT_W-1:0]; // upper bits of b ignored

	adder u_adder (
		.a           (a),
		.b           (b),
		.sub         (sub),
		.sum         (sum),
		.carry       (carry_c),
		.overflow    (overflow_c),
		.less_signed (less_signed)
	);

	barrel_shifter u_shifter (
		.din   (a),
		.shamt (shamt),
		.left  (shift_left),
		.arith (shift_arith),
		.dout  (shifted)
	);

	// no carry out of a - b means a borrow, so a < b unsigned
	assign less_c = (opcode == `OP_SLTU) ? ~carry_c : less_signed;

	always_comb begin
		case (opcode)
			`OP_AND:                   result_c = a & b;
			`OP_OR:                    result_c = a | b;
			`OP_XOR:                   result_c = a ^ b;
			`OP_ADD, `OP_SUB:          result_c = sum;
			`OP_SLT, `OP_SLTU:         result_c = {{(`XLEN-1){1'b0}}, less_c};
			`OP_SLL, `OP_SRL, `OP_SRA: result_c = shifted;
			default:                   result_c = sum;
		endcase
	end

	assign zero_c = ~(|result_c);

	// single output stage, one cycle from in_valid
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			result    <= '0;
			zero      <= 1'b0;
			carry     <= 1'b0;
			overflow  <= 1'b0;
			less      <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin // hold last result when idle
				result   <= result_c;
				zero     <= zero_c;
				carry    <= carry_c;
				overflow <= overflow_c;
				less     <= less_c;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/barrel_shifter.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_consts.svh"

module barrel_shifter (
	input  wire alu_pkg::xlen_t  din,
	input  wire alu_pkg::shamt_t shamt,
	input  wire                  left,
	input  wire                  arith,
	output alu_pkg::xlen_t       dout
);

	logic [2*`XLEN-1:0] dbl;    // double-width source
	logic [`SHAMT_W:0]  offset; // window base, one bit wider than shamt
	logic               fill;   // bits shifted in from the top

	assign fill = arith & din[`XLEN-1];

	always_comb begin
		if (left) begin
			// din sits in the upper half, window slides down
			dbl    = {din, {`XLEN{1'b0}}};
			offset = {1'b1, {`SHAMT_W{1'b0}}} - {1'b0, shamt};
		end else begin
			dbl    = {{`XLEN{fill}}, din}; // sign or zero fill
			offset = {1'b0, shamt};
		end
	end

	assign dout = dbl[offset +: `XLEN];

endmodule

`default_nettype wire

// File: verilog/adder.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_consts.svh"

module adder (
	input  wire alu_pkg::xlen_t a,
	input  wire alu_pkg::xlen_t b,
	input  wire                 sub,
	output alu_pkg::xlen_t      sum,
	output logic                carry,
	output logic                overflow,
	output logic                less_signed
);

	import alu_pkg::*;

	xlen_t b_eff; // b, inverted when subtracting
	logic  sign_a;
	logic  sign_b;
	logic  sign_s;

	assign b_eff = b ^ {`XLEN{sub}};

	// sub doubles as the carry in, giving a + ~b + 1
	assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{`XLEN{1'b0}}, sub};

	assign sign_a = a[`XLEN-1];
	assign sign_b = b_eff[`XLEN-1];
	assign sign_s = sum[`XLEN-1];

	// same operand signs, result sign flipped
	assign overflow = (sign_a == sign_b) && (sign_s != sign_a);

	assign less_signed = overflow ^ sign_s; // true sign of a - b

endmodule

`default_nettype wire

// File: verilog/alu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_consts.svh"

module alu_ctrl (
	input  wire alu_pkg::alu_class_t alu_class,
	input  wire alu_pkg::funct3_t    funct3,
	input  wire alu_pkg::funct7_t    funct7,
	output alu_pkg::alu_opcode_t     opcode
);

	logic alt;    // funct7 bit 5, picks sub / sra
	logic is_reg; // register-register form

	assign alt    = funct7[5];
	assign is_reg = (alu_class == `CLASS_REG);

	always_comb begin
		opcode = `OP_ADD; // fallback for anything unlisted
		case (alu_class)
			`CLASS_MEM: begin
				opcode = `OP_ADD; // base + offset
			end
			`CLASS_BRANCH: begin
				opcode = `OP_SUB; // flags carry the compare
			end
			`CLASS_REG, `CLASS_IMM: begin
				case (funct3)
					3'b000: begin
						// immediates have no subtract form
						if (is_reg && alt) begin
							opcode = `OP_SUB;
						end else begin
							opcode = `OP_ADD;
						end
					end
					3'b001: opcode = `OP_SLL;
					3'b010: opcode = `OP_SLT;
					3'b011: opcode = `OP_SLTU;
					3'b100: opcode = `OP_XOR;
					3'b101: begin
						// srai uses the same funct7 bit as sra
						if (alt) begin
							opcode = `OP_SRA;
						end else begin
							opcode = `OP_SRL;
						end
					end
					3'b110: opcode = `OP_OR;
					3'b111: opcode = `OP_AND;
					default: opcode = `OP_ADD;
				endcase
			end
			default: begin
				opcode = `OP_ADD;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/alu_pkg.sv
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

	typedef logic [`XLEN-1:0]        xlen_t;      // data word
	typedef logic [`ALU_CLASS_W-1:0] alu_class_t; // class from main decoder
	typedef logic [`ALU_OP_W-1:0]    alu_opcode_t;
	typedef logic [`FUNCT3_W-1:0]    funct3_t;
	typedef logic [`FUNCT7_W-1:0]    funct7_t;
	typedef logic [`SHAMT_W-1:0]     shamt_t;     // full 0..63 range

endpackage

`default_nettype wire

// File: verilog/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// datapath widths
`define XLEN        64
`define SHAMT_W     6      // 2**SHAMT_W must equal XLEN
`define ALU_CLASS_W 2
`define ALU_OP_W    4
`define FUNCT3_W    3
`define FUNCT7_W    7

// alu class from the main decoder
`define CLASS_MEM    2'b00 // load/store address
`define CLASS_BRANCH 2'b01 // compare
`define CLASS_REG    2'b10 // register-register
`define CLASS_IMM    2'b11 // register-immediate

// alu operation codes
`define OP_AND  4'b0000
`define OP_OR   4'b0001
`define OP_ADD  4'b0010
`define OP_XOR  4'b0011
`define OP_SLL  4'b0100
`define OP_SRL  4'b0101
`define OP_SUB  4'b0110
`define OP_SLT  4'b0111
`define OP_SRA  4'b1101
`define OP_SLTU 4'b1111

`endif
